// File: sim.f
+incdir+.
core_pkg.sv
alu.sv
cmp.sv
ex_reg.sv
ex_stage.sv
ex_stage_assert.sv
tb_ex_stage.sv

// File: tb_ex_stage.sv
// Self-checking testbench for the execute stage with xorshift stimulus and a reference model
`timescale 1ns/100ps
`include "core_cfg.svh"

module tb_ex_stage;

    import core_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_CYCLES   = 1500;                 // Random stimulus cycles
    localparam int MAX_CYCLES   = NUM_CYCLES * 4 / 3;   // Reset plus margin
    localparam int DRIVE_DLY    = 10;
    localparam int SETTLE_DLY   = 20;                   // Comb outputs sampled here
    localparam logic [31:0] SEED = 32'd78;

    logic clk, rst, stall, flush;
    logic id_is_jalr, id_en, id_jump_taken, id_gpr_we_n;
    logic ra_fwd_en, rb_fwd_en;
    exp_code_t   id_exp_code;
    word_t       id_pc, id_alu_in_0, id_alu_in_1, id_cmp_in_0, id_cmp_in_1;
    word_t       id_mem_wr_data, id_gpr_wr_data, mem_fwd_data;
    alu_op_t     id_alu_op;
    cmp_op_t     id_cmp_op;
    mem_op_t     id_mem_op;
    reg_addr_t   id_rd_addr;
    ex_out_sel_t id_ex_out_sel;
    word_t       fwd_data, br_addr, ex_pc, ex_mem_wr_data, ex_out;
    logic        br_taken, ex_en, ex_gpr_we_n;
    exp_code_t   ex_exp_code;
    mem_op_t     ex_mem_op;
    reg_addr_t   ex_rd_addr;

    // Model of the EX/MEM register
    logic m_en, m_we_n;
    mem_op_t m_mem_op;
    exp_code_t m_exp;
    word_t m_out, m_wr_data, m_pc;
    reg_addr_t m_rd;

    logic [31:0] rng_state = SEED;
    int num_checks, comb_errors, reg_errors, assert_errors, cycle_cnt;

    ex_stage i_ex_stage (.*);

    bind ex_stage ex_stage_assert i_ex_stage_assert (
        .clk (clk), .rst (rst), .flush (flush), .id_is_jalr (id_is_jalr),
        .br_addr (br_addr), .ex_en (ex_en), .ex_gpr_we_n (ex_gpr_we_n)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                         // 100 ns period
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // 32 bit xorshift
    function logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic clear_inputs();
        {stall, flush, id_is_jalr, id_en, id_jump_taken} = '0;
        {ra_fwd_en, rb_fwd_en} = '0;
        id_gpr_we_n    = 1'b1;
        id_exp_code    = '0;
        id_pc          = '0;
        id_alu_op      = ALU_ADD;
        id_alu_in_0    = '0;
        id_alu_in_1    = '0;
        id_cmp_op      = CMP_EQ;
        id_cmp_in_0    = '0;
        id_cmp_in_1    = '0;
        id_mem_op      = MEM_NONE;
        id_mem_wr_data = '0;
        id_rd_addr     = '0;
        id_ex_out_sel  = OUT_ALU;
        id_gpr_wr_data = '0;
        mem_fwd_data   = '0;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = next_rand() % 10;
        id_alu_op = (r == 9) ? alu_op_t'(4'hF) : alu_op_t'(r[3:0]);   // 9 maps to a spare code
        r = next_rand() % 6;
        id_cmp_op = cmp_op_t'(r[2:0]);
        id_alu_in_0 = next_rand();
        id_alu_in_1 = next_rand();
        id_cmp_in_0 = next_rand();
        r = next_rand() % 4;
        if (r == 0)
            id_cmp_in_1 = id_cmp_in_0;                                 // Equal operands
        else if (r == 1)
            id_cmp_in_1 = (next_rand() & 32'h7FFF_FFFF) | {~id_cmp_in_0[31], 31'b0};
        else
            id_cmp_in_1 = next_rand();
        r = next_rand();
        id_ex_out_sel = ex_out_sel_t'(r[1:0]);                         // Includes spare code
        id_exp_code   = r[4:2];
        id_rd_addr    = r[9:5];
        {id_en, id_gpr_we_n, id_is_jalr, ra_fwd_en, rb_fwd_en} = r[14:10];
        id_jump_taken = (r[17:15] == 0);
        r = next_rand() % 7;
        id_mem_op      = mem_op_t'(r[2:0]);
        id_pc          = next_rand() & 32'hFFFF_FFFC;
        id_gpr_wr_data = id_pc + 4;                                    // PC + 4 link
        id_mem_wr_data = next_rand();
        mem_fwd_data   = next_rand();
        r = next_rand();
        stall = (r[2:0] == 0);                                         // About 1 in 8
        flush = (r[7:4] == 0);                                         // About 1 in 16
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic word_t model_alu(input word_t a, input word_t b, input alu_op_t op);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << sh;
            ALU_SRL: return a >> sh;
            ALU_SRA: return (a >> sh) | ({32{a[31]}} & ~(32'hFFFF_FFFF >> sh));
            ALU_NOP: return a;
            default: return '0;
        endcase
    endfunction

    function automatic logic model_cmp(input word_t a, input word_t b, input cmp_op_t op);
        logic lt_s;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);             // Offset binary
        case (op)
            CMP_EQ:  return a == b;
            CMP_NE:  return a != b;
            CMP_LT:  return lt_s;
            CMP_GE:  return !lt_s;
            CMP_LTU: return a < b;
            CMP_GEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t model_alu_out();
        return model_alu(ra_fwd_en ? mem_fwd_data : id_alu_in_0, id_alu_in_1, id_alu_op);
    endfunction

    function automatic word_t model_result();
        case (id_ex_out_sel)
            OUT_ALU: return model_alu_out();
            OUT_CMP: return word_t'(model_cmp(id_cmp_in_0, id_cmp_in_1, id_cmp_op));
            OUT_PCN: return id_gpr_wr_data;
            default: return '0;
        endcase
    endfunction

    // Register model at a rising edge
    task automatic update_model();
        if (rst || flush) begin
            m_en      = 1'b0;
            m_we_n    = 1'b1;
            m_mem_op  = MEM_NONE;
            m_exp     = '0;
            m_out     = '0;
            m_wr_data = '0;
            m_rd      = '0;
            m_pc      = `RESET_PC;
        end else if (!stall) begin
            m_en      = id_en;
            m_we_n    = id_gpr_we_n;
            m_mem_op  = id_mem_op;
            m_exp     = id_exp_code;
            m_out     = model_result();
            m_wr_data = rb_fwd_en ? mem_fwd_data : id_mem_wr_data;
            m_rd      = id_rd_addr;
            m_pc      = id_pc;
        end
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_value(input string what, input word_t got, input word_t exp,
                               input bit is_reg);
        num_checks++;
        assert (got === exp) else begin
            if (is_reg) reg_errors++;
            else comb_errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_comb();
        word_t alu_exp;
        alu_exp = model_alu_out();
        check_value("fwd_data", fwd_data, model_result(), 1'b0);
        check_value("br_addr", br_addr, id_is_jalr ? (alu_exp & ~32'd1) : alu_exp, 1'b0);
        check_value("br_taken", br_taken,
                    (model_cmp(id_cmp_in_0, id_cmp_in_1, id_cmp_op) && id_gpr_we_n)
                    || id_jump_taken, 1'b0);
    endtask

    task automatic check_regs();
        check_value("ex_en", ex_en, m_en, 1'b1);
        check_value("ex_gpr_we_n", ex_gpr_we_n, m_we_n, 1'b1);
        check_value("ex_mem_op", ex_mem_op, m_mem_op, 1'b1);
        check_value("ex_exp_code", ex_exp_code, m_exp, 1'b1);
        check_value("ex_out", ex_out, m_out, 1'b1);
        check_value("ex_mem_wr_data", ex_mem_wr_data, m_wr_data, 1'b1);
        check_value("ex_rd_addr", ex_rd_addr, m_rd, 1'b1);
        check_value("ex_pc", ex_pc, m_pc, 1'b1);
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////

    initial begin
        clear_inputs();
        rst = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            update_model();
            #DRIVE_DLY;
            check_regs();                                // Bubble while in reset
        end
        rst = 1'b0;
        repeat (NUM_CYCLES) begin
            drive_random();
            #SETTLE_DLY;
            check_comb();
            @(posedge clk);
            update_model();                              // Inputs still stable here
            #DRIVE_DLY;
            check_regs();
        end
        assert_errors = i_ex_stage.i_ex_stage_assert.fail_count;
        $display("Checks: %0d, combinational errors: %0d, register errors: %0d, %s %0d",
                 num_checks, comb_errors, reg_errors, "assertion errors:", assert_errors);
        if (comb_errors + reg_errors + assert_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Hang guard
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: ex_stage_assert.sv
// Bound checker for EX/MEM bubble behavior and JALR target alignment
`timescale 1ns/100ps

module ex_stage_assert (
    input logic            clk,
    input logic            rst,
    input logic            flush,
    input logic            id_is_jalr,
    input core_pkg::word_t br_addr,
    input logic            ex_en,
    input logic            ex_gpr_we_n
);

    int fail_count = 0;    // Failed assertions so far

    //////////////////////////////
    // Bubble insertion
    //////////////////////////////

    // Reset leaves an invalid slot with writes disabled
    property bubble_after_reset;
        @(posedge clk) rst |=> (!ex_en && ex_gpr_we_n);
    endproperty

    // Flushed slot never reaches MEM as valid
    property bubble_after_flush;
        @(posedge clk) flush |=> !ex_en;
    endproperty

    //////////////////////////////
    // Branch target
    //////////////////////////////

    property jalr_target_even;
        @(posedge clk) id_is_jalr |-> !br_addr[0];
    endproperty

    assert property (bubble_after_reset) else begin
        fail_count++;
        $error("EX/MEM slot not a bubble after reset");
    end
    assert property (bubble_after_flush) else begin
        fail_count++;
        $error("EX/MEM slot still valid after flush");
    end
    assert property (jalr_target_even) else begin
        fail_count++;
        $error("JALR target has bit 0 set");
    end

endmodule

// File: ex_stage.sv
// Execute stage with MEM forwarding, result select, branch resolution and EX/MEM register
`timescale 1ns/100ps
`include "core_cfg.svh"

module ex_stage (
    input  logic                  clk,
    input  logic                  rst,
    // Pipeline control
    input  logic                  stall,
    input  logic                  flush,
    // ID/EX boundary
    input  logic                  id_is_jalr,      // Target bit 0 cleared
    input  core_pkg::exp_code_t   id_exp_code,
    input  core_pkg::word_t       id_pc,
    input  logic                  id_en,           // Slot holds a valid op
    input  core_pkg::alu_op_t     id_alu_op,
    input  core_pkg::word_t       id_alu_in_0,
    input  core_pkg::word_t       id_alu_in_1,
    input  core_pkg::cmp_op_t     id_cmp_op,
    input  core_pkg::word_t       id_cmp_in_0,
    input  core_pkg::word_t       id_cmp_in_1,
    input  logic                  id_jump_taken,   // Unconditional jump
    input  core_pkg::mem_op_t     id_mem_op,
    input  core_pkg::word_t       id_mem_wr_data,
    input  core_pkg::reg_addr_t   id_rd_addr,
    input  logic                  id_gpr_we_n,
    input  core_pkg::ex_out_sel_t id_ex_out_sel,
    input  core_pkg::word_t       id_gpr_wr_data,  // PC + 4 from decode
    // Forwarding from MEM
    input  logic                  ra_fwd_en,
    input  logic                  rb_fwd_en,
    input  core_pkg::word_t       mem_fwd_data,
    // Back to ID
    output core_pkg::word_t       fwd_data,
    // Down to MEM
    output core_pkg::exp_code_t   ex_exp_code,
    output core_pkg::word_t       ex_pc,
    output logic                  ex_en,
    output core_pkg::mem_op_t     ex_mem_op,
    output core_pkg::word_t       ex_mem_wr_data,
    output core_pkg::reg_addr_t   ex_rd_addr,
    output logic                  ex_gpr_we_n,
    output core_pkg::word_t       ex_out,
    // Back to IF
    output core_pkg::word_t       br_addr,         // Branch or jump target
    output logic                  br_taken
);

    import core_pkg::*;

    word_t alu_in_0;       // First operand after forwarding
    word_t mem_wr_data;    // Store data after forwarding
    word_t alu_val;
    logic  cmp_true;
    word_t ex_out_next;    // Unregistered stage result

    //////////////////////////////
    // MEM forwarding
    //////////////////////////////

    // Load in MEM feeding an op in EX
    assign alu_in_0    = ra_fwd_en ? mem_fwd_data : id_alu_in_0;
    // Store data only
    // The second ALU operand of a store is the immediate
    assign mem_wr_data = rb_fwd_en ? mem_fwd_data : id_mem_wr_data;

    //////////////////////////////
    // Datapath units
    //////////////////////////////

    alu i_alu (
        .arg0 (alu_in_0),
        .arg1 (id_alu_in_1),                       // Never forwarded
        .op   (id_alu_op),
        .val  (alu_val)
    );

    cmp #(
        .WIDTH (`WORD_W)
    ) i_cmp (
        .arg0  (id_cmp_in_0),
        .arg1  (id_cmp_in_1),
        .op    (id_cmp_op),
        .truth (cmp_true)
    );

    //////////////////////////////
    // Result select
    //////////////////////////////

    always_comb begin
        case (id_ex_out_sel)
            OUT_ALU: ex_out_next = alu_val;
            OUT_CMP: ex_out_next = {{(`WORD_W-1){1'b0}}, cmp_true};   // SLT style
            OUT_PCN: ex_out_next = id_gpr_wr_data;                   // Link value
            default: ex_out_next = '0;
        endcase
    end

    assign fwd_data = ex_out_next;                  // Same cycle bypass to ID

    //////////////////////////////
    // Branch resolution
    //////////////////////////////

    // JALR target is rs1 + imm with bit 0 dropped
    assign br_addr  = id_is_jalr ? {alu_val[`WORD_W-1:1], 1'b0} : alu_val;
    // Branches carry a write disable so a taken compare needs we_n high
    assign br_taken = (cmp_true && id_gpr_we_n) || id_jump_taken;

    //////////////////////////////
    // EX/MEM register
    //////////////////////////////

    ex_reg i_ex_reg (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .flush          (flush),
        .ex_out_next    (ex_out_next),
        .id_exp_code    (id_exp_code),
        .id_pc          (id_pc),
        .id_en          (id_en),
        .id_mem_op      (id_mem_op),
        .id_mem_wr_data (mem_wr_data),              // Forwarded value
        .id_rd_addr     (id_rd_addr),
        .id_gpr_we_n    (id_gpr_we_n),
        .ex_exp_code    (ex_exp_code),
        .ex_pc          (ex_pc),
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_rd_addr     (ex_rd_addr),
        .ex_gpr_we_n    (ex_gpr_we_n),
        .ex_out         (ex_out)
    );

endmodule

// File: ex_reg.sv
// EX/MEM pipeline register with synchronous reset, flush bubble and stall hold
`timescale 1ns/100ps
`include "core_cfg.svh"

module ex_reg (
    input  logic                clk,
    input  logic                rst,
    // Pipeline control
    input  logic                stall,
    input  logic                flush,
    // Stage result
    input  core_pkg::word_t     ex_out_next,
    // ID/EX side
    input  core_pkg::exp_code_t id_exp_code,
    input  core_pkg::word_t     id_pc,
    input  logic                id_en,
    input  core_pkg::mem_op_t   id_mem_op,
    input  core_pkg::word_t     id_mem_wr_data,    // Already forwarded
    input  core_pkg::reg_addr_t id_rd_addr,
    input  logic                id_gpr_we_n,
    // EX/MEM side
    output core_pkg::exp_code_t ex_exp_code,
    output core_pkg::word_t     ex_pc,
    output logic                ex_en,
    output core_pkg::mem_op_t   ex_mem_op,
    output core_pkg::word_t     ex_mem_wr_data,
    output core_pkg::reg_addr_t ex_rd_addr,
    output logic                ex_gpr_we_n,
    output core_pkg::word_t     ex_out
);

    import core_pkg::*;

    //////////////////////////////
    // Pipeline register
    //////////////////////////////

    // Priority is rst, flush, stall
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // Bubble with no side effects downstream
            ex_en          <= 1'b0;
            ex_gpr_we_n    <= 1'b1;                 // Write disabled
            ex_mem_op      <= MEM_NONE;             // No memory access
            ex_exp_code    <= '0;                   // No exception
            ex_out         <= '0;
            ex_mem_wr_data <= '0;
            ex_rd_addr     <= '0;
            ex_pc          <= `RESET_PC;
        end else if (!stall) begin
            ex_en          <= id_en;
            ex_gpr_we_n    <= id_gpr_we_n;
            ex_mem_op      <= id_mem_op;
            ex_exp_code    <= id_exp_code;          // Passes through untouched
            ex_out         <= ex_out_next;
            ex_mem_wr_data <= id_mem_wr_data;
            ex_rd_addr     <= id_rd_addr;
            ex_pc          <= id_pc;
        end
        // Stall holds every field
    end

endmodule

// File: cmp.sv
// Combinational comparator for equality, signed and unsigned conditions
`timescale 1ns/100ps
`include "core_cfg.svh"

module cmp #(
    parameter int WIDTH = `WORD_W
) (
    input  logic [WIDTH-1:0]  arg0,
    input  logic [WIDTH-1:0]  arg1,
    input  core_pkg::cmp_op_t op,
    output logic              truth
);

    import core_pkg::*;

    logic eq;       // Operands equal
    logic lt_s;     // Signed less than
    logic lt_u;     // Unsigned less than

    //////////////////////////////
    // Raw relations
    //////////////////////////////

    assign eq   = (arg0 == arg1);
    assign lt_u = (arg0 < arg1);
    assign lt_s = ($signed(arg0) < $signed(arg1));

    //////////////////////////////
    // Condition select
    //////////////////////////////

    // GE forms are the inverse of LT
    always_comb begin
        case (op)
            CMP_EQ:  truth = eq;
            CMP_NE:  truth = ~eq;
            CMP_LT:  truth = lt_s;
            CMP_GE:  truth = ~lt_s;
            CMP_LTU: truth = lt_u;
            CMP_GEU: truth = ~lt_u;
            default: truth = 1'b0;     // Spare codes never true
        endcase
    end

endmodule

// File: alu.sv
// Combinational integer ALU for add, subtract, logic and shift operations
`timescale 1ns/100ps
`include "core_cfg.svh"

module alu (
    input  core_pkg::word_t   arg0,
    input  core_pkg::word_t   arg1,
    input  core_pkg::alu_op_t op,
    output core_pkg::word_t   val
);

    import core_pkg::*;

    // Five bits for a 32 bit word
    localparam int SHAMT_W = $clog2(`WORD_W);

    logic               sub_sel;   // Subtract through the shared adder
    word_t              addend;
    word_t              sum;
    logic [SHAMT_W-1:0] shamt;
    word_t              shl_val;
    word_t              shr_val;
    word_t              sra_val;

    //////////////////////////////
    // Adder
    //////////////////////////////

    // One adder for ADD and SUB
    // Subtract as arg0 + ~arg1 + 1
    assign sub_sel = (op == ALU_SUB);
    assign addend  = sub_sel ? ~arg1 : arg1;
    assign sum     = arg0 + addend + word_t'(sub_sel);

    //////////////////////////////
    // Shifter
    //////////////////////////////

    assign shamt   = arg1[SHAMT_W-1:0];                     // Upper bits ignored
    assign shl_val = arg0 << shamt;
    assign shr_val = arg0 >> shamt;                         // Zero fill
    assign sra_val = word_t'($signed(arg0) >>> shamt);      // Sign fill

    //////////////////////////////
    // Result select
    //////////////////////////////

    always_comb begin
        case (op)
            ALU_ADD: val = sum;
            ALU_SUB: val = sum;
            ALU_AND: val = arg0 & arg1;
            ALU_OR:  val = arg0 | arg1;
            ALU_XOR: val = arg0 ^ arg1;
            ALU_SLL: val = shl_val;
            ALU_SRL: val = shr_val;
            ALU_SRA: val = sra_val;
            // Also used for LUI style moves
            ALU_NOP: val = arg0;
            default: val = '0;                              // Undefined op code
        endcase
    end

endmodule

// File: core_pkg.sv
// Shared datapath types and operation encodings for the integer core
`include "core_cfg.svh"

package core_pkg;

    //////////////////////////////
    // Datapath vectors
    //////////////////////////////

    typedef logic [`WORD_W-1:0]     word_t;      // Data word or PC
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // Destination register number
    typedef logic [`EXP_CODE_W-1:0] exp_code_t;  // Zero means no exception

    //////////////////////////////
    // Operation encodings
    //////////////////////////////

    // ALU operations
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD = 0,
        ALU_SUB = 1,
        ALU_AND = 2,
        ALU_OR  = 3,
        ALU_XOR = 4,
        ALU_SLL = 5,   // Logical left
        ALU_SRL = 6,   // Logical right
        ALU_SRA = 7,   // Arithmetic right
        ALU_NOP = 8    // First operand through
    } alu_op_t;

    // Branch and set-less-than conditions
    typedef enum logic [`CMP_OP_W-1:0] {
        CMP_EQ  = 0,
        CMP_NE  = 1,
        CMP_LT  = 2,   // Signed
        CMP_GE  = 3,   // Signed
        CMP_LTU = 4,
        CMP_GEU = 5
    } cmp_op_t;

    // Memory access kind for the MEM stage
    typedef enum logic [`MEM_OP_W-1:0] {
        MEM_NONE = 0,
        MEM_LW   = 1,
        MEM_LH   = 2,
        MEM_LB   = 3,
        MEM_SW   = 4,
        MEM_SH   = 5,
        MEM_SB   = 6
    } mem_op_t;

    // Execute stage result source
    // Code 3 is spare and yields zero
    typedef enum logic [`EX_OUT_SEL_W-1:0] {
        OUT_ALU = 0,
        OUT_CMP = 1,
        OUT_PCN = 2    // Precomputed PC + 4
    } ex_out_sel_t;

endpackage

// File: core_cfg.svh
// Core configuration macros for datapath widths, operation code widths and reset PC
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Data word and PC width
`define WORD_W 32

// 32 general purpose registers
`define REG_ADDR_W 5

// Exception code carried down the pipe
`define EXP_CODE_W 3

//////////////////////////////
// Operation code widths
//////////////////////////////

`define ALU_OP_W 4
`define CMP_OP_W 3
`define MEM_OP_W 3

// Result selector of the execute stage
`define EX_OUT_SEL_W 2

//////////////////////////////
// Reset values
//////////////////////////////

// PC held in EX/MEM after reset or flush
`define RESET_PC 32'h0000_0000

`endif
